//--- flist.f
verilog/hss_link_pkg.sv
verilog/hss_chan_pkg.sv
verilog/hss_frame_assembler.sv
verilog/hss_frame_disassembler.sv
verilog/hss_frame_tx.sv
verilog/hss_multiplexer.sv
tb/tb_hss_multiplexer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the multiplexer testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_hss_multiplexer \
  -f flist.f \
  --Mdir obj_dir -o Vtb_hss_multiplexer
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/Vtb_hss_multiplexer > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
exit 0

//--- tb/tb_hss_multiplexer.sv
// loopback testbench for the two-channel link multiplexer
// hsl is copied onto ihsl one cycle later, with hsl_rdy held high
// the injector flips one bit in the first payload of each corrupted row
// rows run one after another, a row ends when its frame is accepted as good
// opkt_rdy of a channel stalls per row once that row's packet is on opkt
`timescale 1ns/1ps
`default_nettype none

module tb_hss_multiplexer
  import hss_link_pkg::*, hss_chan_pkg::*;
();

  localparam int NUM_ROWS        = 12;
  localparam int WATCHDOG_CYCLES = 8 + NUM_ROWS * ACK_TIMEOUT * 4;

  logic                          clk;
  logic                          rst_n;
  logic [NUM_CHANS*PKT_BITS-1:0] pkt_data;
  logic [NUM_CHANS-1:0]          pkt_vld;
  logic [NUM_CHANS-1:0]          pkt_rdy;
  logic [FRM_BITS-1:0]           hsl_data;
  logic [KCH_BITS-1:0]           hsl_kchr;
  logic                          hsl_vld;
  logic                          hsl_rdy;
  logic [FRM_BITS-1:0]           ihsl_data;
  logic [KCH_BITS-1:0]           ihsl_kchr;
  logic                          ihsl_vld;
  logic [NUM_CHANS*PKT_BITS-1:0] opkt_data;
  logic [NUM_CHANS-1:0]          opkt_vld;
  logic [NUM_CHANS-1:0]          opkt_rdy;
  logic                          reg_sfrm;
  logic                          reg_tfrm;
  logic                          reg_dfrm;
  logic                          reg_crce;

  // stimulus table, the delivered packet must equal row_val
  int                  row_chan  [NUM_ROWS];
  logic [PKT_BITS-1:0] row_val   [NUM_ROWS];
  bit                  row_corr  [NUM_ROWS];
  int                  row_stall [NUM_ROWS];
  int                  n_rows;
  int                  exp_crce;
  // per channel, row indices in table order
  int                  chan_rows [NUM_CHANS][NUM_ROWS];
  int                  chan_len  [NUM_CHANS];

  logic [31:0]         rng_state;
  int                  data_errs;
  int                  count_errs;
  int                  delivered;
  int                  pos       [NUM_CHANS];
  int                  vcnt      [NUM_CHANS];
  bit                  corrupt_done [NUM_ROWS];
  int                  sfrm_cnt;
  int                  tfrm_cnt;
  int                  dfrm_cnt;
  int                  crce_cnt;
  // words seen on the outgoing link, by type
  int                  link_pld;
  int                  link_ack;
  int                  link_nak;

  hss_multiplexer hss_multiplexer_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .pkt_data  (pkt_data),
    .pkt_vld   (pkt_vld),
    .pkt_rdy   (pkt_rdy),
    .hsl_data  (hsl_data),
    .hsl_kchr  (hsl_kchr),
    .hsl_vld   (hsl_vld),
    .hsl_rdy   (hsl_rdy),
    .ihsl_data (ihsl_data),
    .ihsl_kchr (ihsl_kchr),
    .ihsl_vld  (ihsl_vld),
    .opkt_data (opkt_data),
    .opkt_vld  (opkt_vld),
    .opkt_rdy  (opkt_rdy),
    .reg_sfrm  (reg_sfrm),
    .reg_tfrm  (reg_tfrm),
    .reg_dfrm  (reg_dfrm),
    .reg_crce  (reg_crce)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y ^= y << 13;
    y ^= y >> 17;
    y ^= y << 5;
    return y;
  endfunction

  function automatic logic [PKT_BITS-1:0] next_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic add_row(input int ch, input logic [PKT_BITS-1:0] val,
                         input bit corr, input int stall);
    row_chan[n_rows]  = ch;
    row_val[n_rows]   = val;
    row_corr[n_rows]  = corr;
    row_stall[n_rows] = stall;
    chan_rows[ch][chan_len[ch]] = n_rows;
    chan_len[ch]++;
    if (corr) begin
      exp_crce++;
    end
    n_rows++;
  endtask

  // channel, packet, corrupt, opkt_rdy stall
  task automatic load_table();
    n_rows    = 0;
    exp_crce  = 0;
    rng_state = 32'd29127;
    for (int c = 0; c < NUM_CHANS; c++) begin
      chan_len[c] = 0;
    end
    add_row(0, next_word(),   1'b0, 0);
    add_row(1, next_word(),   1'b0, 0);
    add_row(0, next_word(),   1'b1, 0);
    add_row(1, 32'h0000_0000, 1'b0, 0);
    // long stall, next row on the same channel meets a full output
    add_row(1, next_word(),   1'b0, 40);
    add_row(1, next_word(),   1'b0, 0);
    add_row(0, 32'hffff_ffff, 1'b0, 2);
    add_row(1, next_word(),   1'b1, 3);
    add_row(0, next_word(),   1'b0, 0);
    add_row(1, next_word(),   1'b0, 0);
    add_row(0, next_word(),   1'b1, 0);
    add_row(0, 32'h8000_0001, 1'b0, 0);
  endtask

  task automatic verify_packet(input string name, input logic [PKT_BITS-1:0] got,
                               input logic [PKT_BITS-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %08h expected %08h", $time, name, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_flags(input string name, input logic [NUM_CHANS-1:0] got,
                             input logic [NUM_CHANS-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
      count_errs++;
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
      count_errs++;
    end
  endtask

  // ------------------------------------------------------------------------
  // loopback with corruption injector
  // ------------------------------------------------------------------------
  initial begin
    logic [FRM_BITS-1:0] flip;
    ihsl_data <= '0;
    ihsl_kchr <= '0;
    ihsl_vld  <= 1'b0;
    forever begin
      @(posedge clk);
      flip = '0;
      if (!rst_n) begin
        for (int r = 0; r < NUM_ROWS; r++) begin
          corrupt_done[r] = 1'b0;
        end
      end else if (hsl_vld && hsl_kchr == '0) begin
        // first sending of a corrupted row's payload only
        for (int r = 0; r < NUM_ROWS; r++) begin
          if (row_corr[r] && !corrupt_done[r] && hsl_data == row_val[r]) begin
            flip[(r * 7) % FRM_BITS] = 1'b1;
            corrupt_done[r] = 1'b1;
          end
        end
      end
      ihsl_data <= hsl_data ^ flip;
      ihsl_kchr <= hsl_kchr;
      ihsl_vld  <= hsl_vld;
    end
  end

  // ------------------------------------------------------------------------
  // output monitor, owns opkt_rdy
  // ------------------------------------------------------------------------
  initial begin
    int row;
    opkt_rdy  <= '1;
    delivered = 0;
    data_errs = 0;
    forever begin
      @(posedge clk);
      for (int c = 0; c < NUM_CHANS; c++) begin
        if (!rst_n) begin
          pos[c]  = 0;
          vcnt[c] = 0;
        end else if (opkt_vld[c] && opkt_rdy[c]) begin
          if (pos[c] >= chan_len[c]) begin
            $display("error at %0t: channel %0d delivered a packet that was never sent",
                     $time, c);
            data_errs++;
          end else begin
            row = chan_rows[c][pos[c]];
            verify_packet($sformatf("opkt_data[%0d]", c),
                          opkt_data[c*PKT_BITS +: PKT_BITS], row_val[row]);
            $display("row %0d: channel %0d packet %08h delivered", row, c, row_val[row]);
            pos[c]++;
            delivered++;
          end
          vcnt[c] = 0;
        end else if (opkt_vld[c]) begin
          vcnt[c]++;
        end
        // stall as long as the head row asks for
        if (pos[c] >= chan_len[c]) begin
          opkt_rdy[c] <= 1'b1;
        end else begin
          opkt_rdy[c] <= vcnt[c] >= row_stall[chan_rows[c][pos[c]]];
        end
      end
    end
  end

  // status pulse counters and outgoing link tally
  initial begin
    sfrm_cnt = 0;
    tfrm_cnt = 0;
    dfrm_cnt = 0;
    crce_cnt = 0;
    link_pld = 0;
    link_ack = 0;
    link_nak = 0;
    forever begin
      @(posedge clk);
      if (rst_n) begin
        sfrm_cnt += int'(reg_sfrm);
        tfrm_cnt += int'(reg_tfrm);
        dfrm_cnt += int'(reg_dfrm);
        crce_cnt += int'(reg_crce);
        // kind sits in the top bits of every header word
        if (hsl_vld && hsl_kchr == '0) begin
          link_pld++;
        end else if (hsl_vld && hsl_data[FRM_BITS-1 -: KND_BITS] == FRM_ACK) begin
          link_ack++;
        end else if (hsl_vld && hsl_data[FRM_BITS-1 -: KND_BITS] == FRM_NAK) begin
          link_nak++;
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------
  initial begin
    int ch;
    rst_n      <= 1'b0;
    pkt_data   <= '0;
    pkt_vld    <= '0;
    hsl_rdy    <= 1'b1;
    count_errs = 0;
    load_table();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);
    check_flags("pkt_rdy", pkt_rdy, '1);
    check_flags("opkt_vld", opkt_vld, '0);
    compare_count("reg_sfrm", int'(reg_sfrm), 0);
    compare_count("reg_tfrm", int'(reg_tfrm), 0);
    compare_count("reg_dfrm", int'(reg_dfrm), 0);
    compare_count("reg_crce", int'(reg_crce), 0);
    $display("reset state checked");

    for (int r = 0; r < n_rows; r++) begin
      ch = row_chan[r];
      @(posedge clk);
      pkt_data[ch*PKT_BITS +: PKT_BITS] <= row_val[r];
      pkt_vld[ch]                       <= 1'b1;
      // pkt_rdy is combinational, look at it between edges
      @(negedge clk);
      while (!pkt_rdy[ch]) begin
        @(negedge clk);
      end
      @(posedge clk);
      pkt_vld[ch] <= 1'b0;
      // one good frame per row at the receiver
      while (dfrm_cnt < r + 1) begin
        @(negedge clk);
      end
    end

    while (delivered < n_rows) begin
      @(negedge clk);
    end
    // quiet period, late duplicates would show up here
    repeat (ACK_TIMEOUT) @(negedge clk);

    compare_count("delivered packets", delivered, n_rows);
    compare_count("reg_dfrm pulses", dfrm_cnt, n_rows);
    compare_count("reg_crce pulses", crce_cnt, exp_crce);
    // every data frame on the link is answered once, good ones with an ack
    compare_count("ack frames on link", link_ack, n_rows);
    compare_count("nak frames on link", link_nak, link_pld - n_rows);
    compare_count("reg_sfrm pulses", sfrm_cnt, link_pld);
    compare_count("reg_tfrm pulses", tfrm_cnt, link_pld + link_ack + link_nak);
    check_flags("pkt_rdy at end", pkt_rdy, '1);
    $display("summary: rows %0d delivered %0d crc errors %0d frames sent %0d failures %0d",
             n_rows, delivered, crce_cnt, sfrm_cnt, data_errs + count_errs);
    if (data_errs + count_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/hss_chan_pkg.sv
// local channel side constants
// NUM_CHANS must equal 2**CHN_BITS, the round-robin index wraps on its width
// a packet fills exactly one link payload word
`default_nettype none

package hss_chan_pkg;

  // number of local channels and index width
  localparam int NUM_CHANS   = 2;
  localparam int CHN_BITS    = 1;

  // packet width
  localparam int PKT_BITS    = 32;

  // cycles without an answer before the outstanding frame is resent
  localparam int ACK_TIMEOUT = 64;
  localparam int TMO_BITS    = $clog2(ACK_TIMEOUT);

endpackage

`default_nettype wire

//--- verilog/hss_frame_assembler.sv
// builds data frames from the local channels, one frame outstanding per link
// stop-and-wait: pkt_rdy stays low until the frame is retired by an answer
// pkt_rdy of a channel may depend on pkt_vld of the others in the same cycle
// a nak or ACK_TIMEOUT cycles of silence resend the same frame
`timescale 1ns/1ps
`default_nettype none

module hss_frame_assembler
  import hss_link_pkg::*, hss_chan_pkg::*;
(
  input  wire                           clk,
  input  wire                           rst_n,

  // local packets in
  input  wire  [NUM_CHANS*PKT_BITS-1:0] pkt_data,
  input  wire  [NUM_CHANS-1:0]          pkt_vld,
  output logic [NUM_CHANS-1:0]          pkt_rdy,

  // remote answer from the disassembler
  input  wire                           rack_type,
  input  wire  [SEQ_BITS-1:0]           rack_seq,
  input  wire                           rack_vld,

  // frame stream to the transmitter
  output logic [FRM_BITS-1:0]           frm_data,
  output logic [KCH_BITS-1:0]           frm_kchr,
  output logic                          frm_last,
  output logic                          frm_vld,
  input  wire                           frm_rdy,

  output logic                          reg_sfrm
);

  logic                busy;
  logic                snd_hdr;
  logic                snd_pld;
  logic                waiting;
  logic                take;
  logic                retire;
  logic                replay;
  logic [CHN_BITS-1:0] rr_last;
  logic [CHN_BITS-1:0] sel_chan;
  logic                sel_vld;
  logic [CHN_BITS-1:0] cur_chan;
  logic [PKT_BITS-1:0] cur_pkt;
  logic [SEQ_BITS-1:0] seq;
  logic [TMO_BITS-1:0] tmo_cnt;
  hss_hdr_u            tx_hdr;

  // ------------------------------------------------------------------------
  // round-robin pick, starting after the last channel served
  // ------------------------------------------------------------------------
  always_comb begin
    logic [CHN_BITS-1:0] idx;
    sel_vld  = 1'b0;
    sel_chan = '0;
    // walk down so the nearest valid channel is the last one assigned
    for (int i = NUM_CHANS - 1; i >= 0; i--) begin
      idx = rr_last + CHN_BITS'(i + 1);
      if (pkt_vld[idx]) begin
        sel_vld  = 1'b1;
        sel_chan = idx;
      end
    end
  end

  // idle with nothing pending: every channel ready
  always_comb begin
    for (int i = 0; i < NUM_CHANS; i++) begin
      pkt_rdy[i] = !busy && (!sel_vld || sel_chan == CHN_BITS'(i));
    end
  end

  assign take    = !busy && sel_vld;
  assign waiting = busy && !snd_hdr && !snd_pld;

  // ack of our seq, or nak asking for the next one, means delivered
  assign retire  = waiting && rack_vld &&
                   ((rack_type && rack_seq == seq) ||
                    (!rack_type && rack_seq == SEQ_BITS'(seq + 1'b1)));
  assign replay  = waiting && !retire &&
                   ((rack_vld && !rack_type && rack_seq == seq) ||
                    tmo_cnt == TMO_BITS'(ACK_TIMEOUT - 1));

  // ------------------------------------------------------------------------
  // frame words
  // ------------------------------------------------------------------------
  always_comb begin
    tx_hdr           = '0;
    tx_hdr.data.kind = FRM_DATA;
    tx_hdr.data.chan = CHF_BITS'(cur_chan);
    tx_hdr.data.seq  = seq;
    tx_hdr.data.chk  = hss_chk(cur_pkt);
  end

  assign frm_vld  = snd_hdr || snd_pld;
  assign frm_last = snd_pld;
  assign frm_kchr = {KCH_BITS{snd_hdr}};
  assign frm_data = snd_hdr ? tx_hdr : cur_pkt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      snd_hdr  <= 1'b0;
      snd_pld  <= 1'b0;
      rr_last  <= '0;
      seq      <= '0;
      tmo_cnt  <= '0;
      reg_sfrm <= 1'b0;
    end else begin
      reg_sfrm <= snd_pld && frm_rdy;
      if (take) begin
        busy    <= 1'b1;
        snd_hdr <= 1'b1;
        rr_last <= sel_chan;
      end
      // header goes, payload next
      if (snd_hdr && frm_rdy) begin
        snd_hdr <= 1'b0;
        snd_pld <= 1'b1;
      end
      if (snd_pld && frm_rdy) begin
        snd_pld <= 1'b0;
      end
      // timer only runs while the answer is awaited
      tmo_cnt <= waiting ? tmo_cnt + 1'b1 : '0;
      if (retire) begin
        busy <= 1'b0;
        seq  <= seq + 1'b1;
      end
      if (replay) begin
        snd_hdr <= 1'b1;
      end
    end
  end

  // outstanding packet, kept for resend
  always_ff @(posedge clk) begin
    if (take) begin
      cur_chan <= sel_chan;
      cur_pkt  <= pkt_data[sel_chan*PKT_BITS +: PKT_BITS];
    end
  end

endmodule

`default_nettype wire

//--- verilog/hss_frame_disassembler.sv
// decodes incoming link words, there is no back-pressure on the link side
// one expected seq for the whole link, matching the stop-and-wait sender
// a payload word with no data header before it is ignored
// a dropped frame is answered with a nak carrying the expected seq
`timescale 1ns/1ps
`default_nettype none

module hss_frame_disassembler
  import hss_link_pkg::*, hss_chan_pkg::*;
(
  input  wire                           clk,
  input  wire                           rst_n,

  // link words in
  input  wire  [FRM_BITS-1:0]           ihsl_data,
  input  wire  [KCH_BITS-1:0]           ihsl_kchr,
  input  wire                           ihsl_vld,

  // remote answer to the assembler, single-cycle pulse
  output logic                          rack_type,
  output logic [SEQ_BITS-1:0]           rack_seq,
  output logic                          rack_vld,

  // local answer to the transmitter
  output logic                          lack_type,
  output logic [SEQ_BITS-1:0]           lack_seq,
  output logic                          lack_rts,
  input  wire                           lack_done,

  // packets out
  output logic [NUM_CHANS*PKT_BITS-1:0] opkt_data,
  output logic [NUM_CHANS-1:0]          opkt_vld,
  input  wire  [NUM_CHANS-1:0]          opkt_rdy,

  output logic                          reg_dfrm,
  output logic                          reg_crce
);

  hss_hdr_u            rx_hdr;
  logic                hdr_word;
  logic                pld_word;
  logic                hdr_pend;
  logic [CHF_BITS-1:0] hdr_chan;
  logic [SEQ_BITS-1:0] hdr_seq;
  logic [CHK_BITS-1:0] hdr_chk;
  logic [SEQ_BITS-1:0] exp_seq;
  logic [CHN_BITS-1:0] dst;
  logic                chk_ok;
  logic                chan_ok;
  logic                seq_ok;
  logic                room;
  logic                good;

  // ------------------------------------------------------------------------
  // word decode and payload checks
  // ------------------------------------------------------------------------
  assign rx_hdr   = ihsl_data;
  assign hdr_word = ihsl_vld && (|ihsl_kchr);
  assign pld_word = ihsl_vld && !(|ihsl_kchr) && hdr_pend;

  assign dst      = hdr_chan[CHN_BITS-1:0];
  assign chk_ok   = hss_chk(ihsl_data) == hdr_chk;
  assign chan_ok  = hdr_chan < CHF_BITS'(NUM_CHANS);
  assign seq_ok   = hdr_seq == exp_seq;
  // output register free, or emptied this cycle
  assign room     = !opkt_vld[dst] || opkt_rdy[dst];
  assign good     = pld_word && chk_ok && chan_ok && seq_ok && room;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hdr_pend  <= 1'b0;
      exp_seq   <= '0;
      rack_vld  <= 1'b0;
      rack_type <= 1'b0;
      rack_seq  <= '0;
      lack_rts  <= 1'b0;
      lack_type <= 1'b0;
      lack_seq  <= '0;
      opkt_vld  <= '0;
      reg_dfrm  <= 1'b0;
      reg_crce  <= 1'b0;
    end else begin
      // ack and nak headers pass straight on to the assembler
      rack_vld <= hdr_word &&
                  (rx_hdr.ack.kind == FRM_ACK || rx_hdr.ack.kind == FRM_NAK);
      if (hdr_word) begin
        rack_type <= rx_hdr.ack.kind == FRM_ACK;
        rack_seq  <= rx_hdr.ack.seq;
      end
      reg_dfrm <= good;
      reg_crce <= pld_word && !chk_ok;

      // data header waits for its payload
      if (hdr_word) begin
        hdr_pend <= rx_hdr.data.kind == FRM_DATA;
      end else if (pld_word) begin
        hdr_pend <= 1'b0;
      end

      // newest answer replaces one not yet sent
      if (lack_done) begin
        lack_rts <= 1'b0;
      end
      if (pld_word) begin
        lack_rts  <= 1'b1;
        lack_type <= good;
        lack_seq  <= good ? hdr_seq : exp_seq;
      end
      if (good) begin
        exp_seq <= exp_seq + 1'b1;
      end

      for (int i = 0; i < NUM_CHANS; i++) begin
        if (opkt_rdy[i]) begin
          opkt_vld[i] <= 1'b0;
        end
      end
      if (good) begin
        opkt_vld[dst] <= 1'b1;
      end
    end
  end

  // header fields and delivered packets
  always_ff @(posedge clk) begin
    if (hdr_word) begin
      hdr_chan <= rx_hdr.data.chan;
      hdr_seq  <= rx_hdr.data.seq;
      hdr_chk  <= rx_hdr.data.chk;
    end
    if (good) begin
      opkt_data[dst*PKT_BITS +: PKT_BITS] <= ihsl_data;
    end
  end

endmodule

`default_nettype wire

//--- verilog/hss_frame_tx.sv
// single register stage onto the outgoing link
// ack and nak frames go ahead of data, but only between data frames
// hsl_rdy low freezes the output and blocks both sources
`timescale 1ns/1ps
`default_nettype none

module hss_frame_tx
  import hss_link_pkg::*;
(
  input  wire                 clk,
  input  wire                 rst_n,

  // data frames from the assembler
  input  wire  [FRM_BITS-1:0] frm_data,
  input  wire  [KCH_BITS-1:0] frm_kchr,
  input  wire                 frm_last,
  input  wire                 frm_vld,
  output logic                frm_rdy,

  // local answer from the disassembler
  input  wire                 lack_type,
  input  wire  [SEQ_BITS-1:0] lack_seq,
  input  wire                 lack_rts,
  output logic                lack_done,

  // link out
  output logic [FRM_BITS-1:0] hsl_data,
  output logic [KCH_BITS-1:0] hsl_kchr,
  output logic                hsl_vld,
  input  wire                 hsl_rdy,

  output logic                reg_tfrm
);

  hss_hdr_u ack_hdr;
  logic     mid_frm;
  logic     frm_take;

  // one-word answer frame
  always_comb begin
    ack_hdr          = '0;
    ack_hdr.ack.kind = lack_type ? FRM_ACK : FRM_NAK;
    ack_hdr.ack.seq  = lack_seq;
  end

  // ------------------------------------------------------------------------
  // arbitration at frame boundaries
  // ------------------------------------------------------------------------
  assign lack_done = hsl_rdy && lack_rts && !mid_frm;
  assign frm_rdy   = hsl_rdy && (mid_frm || !lack_rts);
  assign frm_take  = frm_vld && frm_rdy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mid_frm  <= 1'b0;
      hsl_vld  <= 1'b0;
      reg_tfrm <= 1'b0;
    end else begin
      reg_tfrm <= lack_done || (frm_take && frm_last);
      if (hsl_rdy) begin
        hsl_vld <= lack_done || frm_take;
      end
      // header taken, payload still to come
      if (frm_take) begin
        mid_frm <= !frm_last;
      end
    end
  end

  // link word register
  always_ff @(posedge clk) begin
    if (lack_done) begin
      hsl_data <= ack_hdr;
      hsl_kchr <= '1;
    end else if (frm_take) begin
      hsl_data <= frm_data;
      hsl_kchr <= frm_kchr;
    end
  end

endmodule

`default_nettype wire

//--- verilog/hss_link_pkg.sv
// link word formats shared by both ends of the serial link
// a data frame is a header word (k-char flag set) followed by one payload word
// the kind field is the top of every header, so one word decodes either way
// channel field is wider than the channel index, to leave room for growth
`default_nettype none

package hss_link_pkg;

  // ------------------------------------------------------------------------
  // word and field widths
  // ------------------------------------------------------------------------
  localparam int FRM_BITS  = 32;
  localparam int KCH_BITS  = 1;
  localparam int KND_BITS  = 2;
  localparam int SEQ_BITS  = 5;
  localparam int CHK_BITS  = 8;
  // channel field in the data header
  localparam int CHF_BITS  = 3;
  // reserved fill up to a full link word
  localparam int DRSV_BITS = FRM_BITS - KND_BITS - CHF_BITS - SEQ_BITS - CHK_BITS;
  localparam int ARSV_BITS = FRM_BITS - KND_BITS - SEQ_BITS;

  // frame kinds, code 3 is unused
  typedef enum logic [KND_BITS-1:0] {
    FRM_DATA = 2'd0,
    FRM_ACK  = 2'd1,
    FRM_NAK  = 2'd2
  } frm_kind_e;

  // ------------------------------------------------------------------------
  // header words
  // ------------------------------------------------------------------------
  typedef struct packed {
    frm_kind_e            kind;
    logic [CHF_BITS-1:0]  chan;
    logic [SEQ_BITS-1:0]  seq;
    logic [CHK_BITS-1:0]  chk;
    logic [DRSV_BITS-1:0] rsvd;
  } data_hdr_t;

  // nak carries the seq the receiver expects next
  typedef struct packed {
    frm_kind_e            kind;
    logic [SEQ_BITS-1:0]  seq;
    logic [ARSV_BITS-1:0] rsvd;
  } ack_hdr_t;

  typedef union packed {
    data_hdr_t data;
    ack_hdr_t  ack;
  } hss_hdr_u;

  // byte-wise xor of the payload word
  function automatic logic [CHK_BITS-1:0] hss_chk(input logic [FRM_BITS-1:0] word);
    logic [CHK_BITS-1:0] acc;
    acc = '0;
    for (int i = 0; i < FRM_BITS / CHK_BITS; i++) begin
      acc ^= word[i*CHK_BITS +: CHK_BITS];
    end
    return acc;
  endfunction

endpackage

`default_nettype wire

//--- verilog/hss_multiplexer.sv
// two-channel serial link multiplexer, stop-and-wait with ack and nak
// the incoming link has no ready, words are taken as they arrive
// per-channel streams are packed vectors, channel 0 in the low bits
// status outputs are single-cycle pulses
`timescale 1ns/1ps
`default_nettype none

module hss_multiplexer
  import hss_link_pkg::*, hss_chan_pkg::*;
(
  input  wire                           clk,
  input  wire                           rst_n,

  // local packets in
  input  wire  [NUM_CHANS*PKT_BITS-1:0] pkt_data,
  input  wire  [NUM_CHANS-1:0]          pkt_vld,
  output logic [NUM_CHANS-1:0]          pkt_rdy,

  // link out
  output logic [FRM_BITS-1:0]           hsl_data,
  output logic [KCH_BITS-1:0]           hsl_kchr,
  output logic                          hsl_vld,
  input  wire                           hsl_rdy,

  // link in
  input  wire  [FRM_BITS-1:0]           ihsl_data,
  input  wire  [KCH_BITS-1:0]           ihsl_kchr,
  input  wire                           ihsl_vld,

  // packets out
  output logic [NUM_CHANS*PKT_BITS-1:0] opkt_data,
  output logic [NUM_CHANS-1:0]          opkt_vld,
  input  wire  [NUM_CHANS-1:0]          opkt_rdy,

  // status pulses
  output logic                          reg_sfrm,
  output logic                          reg_tfrm,
  output logic                          reg_dfrm,
  output logic                          reg_crce
);

  // ------------------------------------------------------------------------
  // internal streams
  // ------------------------------------------------------------------------
  // assembler to transmitter
  logic [FRM_BITS-1:0] frm_data;
  logic [KCH_BITS-1:0] frm_kchr;
  logic                frm_last;
  logic                frm_vld;
  logic                frm_rdy;

  // remote answer, disassembler to assembler
  logic                rack_type;
  logic [SEQ_BITS-1:0] rack_seq;
  logic                rack_vld;

  // local answer, disassembler to transmitter
  logic                lack_type;
  logic [SEQ_BITS-1:0] lack_seq;
  logic                lack_rts;
  logic                lack_done;

  hss_frame_assembler hss_frame_assembler_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .pkt_data  (pkt_data),
    .pkt_vld   (pkt_vld),
    .pkt_rdy   (pkt_rdy),
    .rack_type (rack_type),
    .rack_seq  (rack_seq),
    .rack_vld  (rack_vld),
    .frm_data  (frm_data),
    .frm_kchr  (frm_kchr),
    .frm_last  (frm_last),
    .frm_vld   (frm_vld),
    .frm_rdy   (frm_rdy),
    .reg_sfrm  (reg_sfrm)
  );

  hss_frame_disassembler hss_frame_disassembler_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .ihsl_data (ihsl_data),
    .ihsl_kchr (ihsl_kchr),
    .ihsl_vld  (ihsl_vld),
    .rack_type (rack_type),
    .rack_seq  (rack_seq),
    .rack_vld  (rack_vld),
    .lack_type (lack_type),
    .lack_seq  (lack_seq),
    .lack_rts  (lack_rts),
    .lack_done (lack_done),
    .opkt_data (opkt_data),
    .opkt_vld  (opkt_vld),
    .opkt_rdy  (opkt_rdy),
    .reg_dfrm  (reg_dfrm),
    .reg_crce  (reg_crce)
  );

  // answers and data merge here onto the link
  hss_frame_tx hss_frame_tx_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .frm_data  (frm_data),
    .frm_kchr  (frm_kchr),
    .frm_last  (frm_last),
    .frm_vld   (frm_vld),
    .frm_rdy   (frm_rdy),
    .lack_type (lack_type),
    .lack_seq  (lack_seq),
    .lack_rts  (lack_rts),
    .lack_done (lack_done),
    .hsl_data  (hsl_data),
    .hsl_kchr  (hsl_kchr),
    .hsl_vld   (hsl_vld),
    .hsl_rdy   (hsl_rdy),
    .reg_tfrm  (reg_tfrm)
  );

endmodule

`default_nettype wire
